// ==== source/cu_isa_pkg.sv ====
package cu_isa_pkg;

	// ------------------------------------------------------------
	// opcodes, numbering follows the instruction set listing
	// ------------------------------------------------------------
	typedef enum logic [5:0]
	{
		OP_LDAC   = 6'd1,  // ac <- dmem[ar]
		OP_MVACR  = 6'd4,
		OP_MVACR1 = 6'd8,
		OP_MVACR2 = 6'd9,
		OP_ADDTR  = 6'd10, // ac + tr, result back to tr
		OP_ADDR1  = 6'd11,
		OP_ADDR2  = 6'd12,
		OP_MULT   = 6'd15, // ac * r
		OP_SUB    = 6'd19, // ac - r
		OP_CLRR   = 6'd23,
		OP_CLRAC  = 6'd24,
		OP_CLRTR  = 6'd25,
		OP_INCAC  = 6'd26,
		OP_JPNZ   = 6'd27, // jump when z is low
		OP_ENDOP  = 6'd28, // halt
		OP_CLRR1  = 6'd38,
		OP_CLRR2  = 6'd39
	} opcode_e;

	// ------------------------------------------------------------
	// datapath selects
	// ------------------------------------------------------------
	typedef enum logic [2:0]
	{
		ALU_ADD  = 3'd0,
		ALU_SUB  = 3'd1,
		ALU_MULT = 3'd2,
		ALU_PASS = 3'd4  // bus value straight into ac
	} alu_mode_e;

	typedef enum logic [3:0]
	{
		BUS_IMEM = 4'd0,
		BUS_DMEM = 4'd1,
		BUS_PC   = 4'd2,
		BUS_DR   = 4'd3,
		BUS_R    = 4'd4,
		BUS_AC   = 4'd5,
		BUS_TR   = 4'd6,
		BUS_R1   = 4'd7,
		BUS_R2   = 4'd8
	} bus_src_e;

	typedef enum logic [1:0]
	{
		INC_NONE = 2'd0,
		INC_PC   = 2'd1,
		INC_AC   = 2'd2
	} inc_e;

endpackage

// ==== source/cu_ctrl_pkg.sv ====
package cu_ctrl_pkg;
	import cu_isa_pkg::*;

	// ------------------------------------------------------------
	// control word seen by the datapath
	// ------------------------------------------------------------

	// register write enables
	typedef struct packed
	{
		logic ar;
		logic pc;
		logic dr;
		logic ir;
		logic r;
		logic tr;
		logic ac;
		logic r1;
		logic r2;
	} reg_we_t;

	// synchronous clears in the datapath
	typedef struct packed
	{
		logic r;
		logic ac;
		logic tr;
		logic r1;
		logic r2;
	} reg_clr_t;

	// all zero is the inactive word
	typedef struct packed
	{
		reg_we_t   write_en;
		inc_e      inc;
		alu_mode_e alu_mode;
		bus_src_e  bus_ld;
		reg_clr_t  clr;
	} ctrl_word_t;

	// ------------------------------------------------------------
	// sequencer stages
	// ------------------------------------------------------------
	typedef enum logic [3:0]
	{
		BOOT,       // reset state, leaves on first edge
		FETCH1,
		FETCH2,
		FETCH_WAIT, // instruction memory latency
		FETCH3,
		DECODE,
		EXEC1,
		EXEC_SKIP,  // jpnz not taken
		EXECX,
		EXEC2,
		IDLE        // after endop, until reset
	} stage_e;

endpackage

// ==== source/cu_sequencer.sv ====
module cu_sequencer
	import cu_isa_pkg::*;
	import cu_ctrl_pkg::*;
#(
	parameter int unsigned FETCH_WAIT_CYCLES = 1
)
(
	input  logic    clk,
	input  logic    rst_n,
	input  opcode_e ir,
	input  logic    z,
	output stage_e  next_stage
);

	// index of the last wait cycle, wraps for 0 but FETCH_WAIT is never entered then
	localparam logic [1:0] WAIT_LAST = 2'(FETCH_WAIT_CYCLES - 1);

	stage_e     stage;
	logic [1:0] wait_cnt; // wait cycles already spent

	// ------------------------------------------------------------
	// stage register and wait counter
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			stage    <= BOOT;
			wait_cnt <= 2'd0;
		end
		else
		begin
			stage <= next_stage;
			if (stage == FETCH_WAIT)
				wait_cnt <= wait_cnt + 2'd1;
			else
				wait_cnt <= 2'd0;
		end
	end

	// ------------------------------------------------------------
	// next stage
	// ------------------------------------------------------------
	always_comb
	begin
		next_stage = FETCH1;
		case (stage)
			BOOT:
				next_stage = FETCH1;
			FETCH1:
				next_stage = FETCH2;
			FETCH2:
			begin
				if (FETCH_WAIT_CYCLES == 0)
					next_stage = FETCH3; // no memory latency
				else
					next_stage = FETCH_WAIT;
			end
			FETCH_WAIT:
			begin
				if (wait_cnt == WAIT_LAST)
					next_stage = FETCH3;
				else
					next_stage = FETCH_WAIT;
			end
			FETCH3:
				next_stage = DECODE; // ir loads on this edge
			DECODE:
			begin
				// jpnz resolved here, the execute stages never look at z
				if (ir == OP_JPNZ && z)
					next_stage = EXEC_SKIP;
				else
					next_stage = EXEC1;
			end
			EXEC1:
			begin
				case (ir)
					OP_ADDTR, OP_ADDR1, OP_ADDR2:
						next_stage = EXEC2;  // write back
					OP_LDAC, OP_JPNZ:
						next_stage = EXECX;  // second memory cycle
					OP_ENDOP:
						next_stage = IDLE;
					default:
						next_stage = FETCH1; // single stage ops and noop
				endcase
			end
			EXECX:
				next_stage = EXEC2;
			EXEC2:
				next_stage = FETCH1;
			EXEC_SKIP:
				next_stage = FETCH1;
			IDLE:
				next_stage = IDLE;
			default:
				next_stage = FETCH1;
		endcase
	end

endmodule

// ==== source/cu_microcode.sv ====
module cu_microcode
	import cu_isa_pkg::*;
	import cu_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  stage_e     next_stage,
	input  opcode_e    ir,
	output ctrl_word_t ctrl,
	output logic       end_op
);

	ctrl_word_t word_nx;
	logic       end_op_nx;

	// word for the stage entered on the next edge
	always_comb
	begin
		word_nx   = '0;
		end_op_nx = 1'b0;
		case (next_stage)
			// ------------------------------------------------------------
			// fetch
			// ------------------------------------------------------------
			FETCH1:
			begin
				word_nx.write_en.ar = 1'b1;
				word_nx.bus_ld      = BUS_PC;
			end
			FETCH2:
			begin
				word_nx.write_en.dr = 1'b1;
				word_nx.bus_ld      = BUS_IMEM;
				word_nx.inc         = INC_PC;
			end
			FETCH_WAIT:
			begin
				word_nx.write_en.dr = 1'b1; // hold dr on imem until data settles
				word_nx.bus_ld      = BUS_IMEM;
			end
			FETCH3:
			begin
				word_nx.write_en.ar = 1'b1;
				word_nx.write_en.ir = 1'b1;
				word_nx.bus_ld      = BUS_DR;
			end

			// ------------------------------------------------------------
			// first execute stage
			// ------------------------------------------------------------
			EXEC1:
			begin
				case (ir)
					OP_MVACR:
					begin
						word_nx.write_en.r = 1'b1;
						word_nx.bus_ld     = BUS_AC;
					end
					OP_MVACR1:
					begin
						word_nx.write_en.r1 = 1'b1;
						word_nx.bus_ld      = BUS_AC;
					end
					OP_MVACR2:
					begin
						word_nx.write_en.r2 = 1'b1;
						word_nx.bus_ld      = BUS_AC;
					end
					OP_SUB, OP_MULT:
					begin
						word_nx.write_en.ac = 1'b1;
						word_nx.bus_ld      = BUS_R;
						word_nx.alu_mode    = (ir == OP_SUB) ? ALU_SUB : ALU_MULT;
					end
					OP_ADDTR, OP_ADDR1, OP_ADDR2:
					begin
						word_nx.write_en.ac = 1'b1;
						word_nx.alu_mode    = ALU_ADD;
						case (ir)
							OP_ADDTR: word_nx.bus_ld = BUS_TR;
							OP_ADDR1: word_nx.bus_ld = BUS_R1;
							default:  word_nx.bus_ld = BUS_R2;
						endcase
					end
					OP_CLRR:  word_nx.clr.r  = 1'b1;
					OP_CLRAC: word_nx.clr.ac = 1'b1;
					OP_CLRTR: word_nx.clr.tr = 1'b1;
					OP_CLRR1: word_nx.clr.r1 = 1'b1;
					OP_CLRR2: word_nx.clr.r2 = 1'b1;
					OP_INCAC: word_nx.inc    = INC_AC;
					OP_LDAC:
					begin
						word_nx.write_en.dr = 1'b1;
						word_nx.bus_ld      = BUS_DMEM;
					end
					OP_JPNZ:
					begin
						word_nx.write_en.dr = 1'b1; // taken path only, target from imem
						word_nx.bus_ld      = BUS_IMEM;
					end
					OP_ENDOP: end_op_nx = 1'b1;
					default:  word_nx = '0; // noop
				endcase
			end

			// ------------------------------------------------------------
			// second memory cycle
			// ------------------------------------------------------------
			EXECX:
			begin
				case (ir)
					OP_LDAC:
					begin
						word_nx.write_en.dr = 1'b1;
						word_nx.bus_ld      = BUS_DMEM;
					end
					OP_JPNZ:
					begin
						word_nx.write_en.dr = 1'b1;
						word_nx.bus_ld      = BUS_IMEM;
					end
					default: word_nx = '0;
				endcase
			end

			// ------------------------------------------------------------
			// last execute stage
			// ------------------------------------------------------------
			EXEC2:
			begin
				case (ir)
					OP_ADDTR, OP_ADDR1, OP_ADDR2:
					begin
						word_nx.bus_ld   = BUS_AC; // sum back to the source register
						word_nx.alu_mode = ALU_ADD;
						case (ir)
							OP_ADDTR: word_nx.write_en.tr = 1'b1;
							OP_ADDR1: word_nx.write_en.r1 = 1'b1;
							default:  word_nx.write_en.r2 = 1'b1;
						endcase
					end
					OP_LDAC:
					begin
						word_nx.write_en.ac = 1'b1;
						word_nx.bus_ld      = BUS_DR;
						word_nx.alu_mode    = ALU_PASS;
					end
					OP_JPNZ:
					begin
						word_nx.write_en.pc = 1'b1;
						word_nx.bus_ld      = BUS_DR;
					end
					default: word_nx = '0;
				endcase
			end

			EXEC_SKIP:
				word_nx.inc = INC_PC; // step over the jump target

			// boot, decode and idle stay inactive
			default: word_nx = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ctrl   <= '0;
			end_op <= 1'b0;
		end
		else
		begin
			ctrl   <= word_nx;
			end_op <= end_op_nx;
		end
	end

endmodule

// ==== source/control_unit.sv ====
module control_unit
	import cu_isa_pkg::*;
	import cu_ctrl_pkg::*;
#(
	parameter int unsigned FETCH_WAIT_CYCLES = 1 // imem wait cycles, 0 to 3
)
(
	input  logic       clk,
	input  logic       rst_n,
	input  opcode_e    ir,
	input  logic       z,
	output ctrl_word_t ctrl,
	output logic       end_op
);

	stage_e next_stage; // stage entered on the coming edge

	// ------------------------------------------------------------
	// stage sequencing
	// ------------------------------------------------------------
	cu_sequencer #(
		.FETCH_WAIT_CYCLES (FETCH_WAIT_CYCLES)
	) u_sequencer (
		.clk        (clk),
		.rst_n      (rst_n),
		.ir         (ir),
		.z          (z),
		.next_stage (next_stage)
	);

	// ------------------------------------------------------------
	// registered control word
	// ------------------------------------------------------------
	cu_microcode u_microcode (
		.clk        (clk),
		.rst_n      (rst_n),
		.next_stage (next_stage),
		.ir         (ir),
		.ctrl       (ctrl),
		.end_op     (end_op)
	);

endmodule

// ==== test/tb_clock_gen.sv ====
module tb_clock_gen
#(
	parameter int PERIOD = 8
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk; // free running
	end

endmodule

// ==== test/tb_control_unit.sv ====
module tb_control_unit
	import cu_isa_pkg::*;
	import cu_ctrl_pkg::*;
();

	localparam int WAIT_LIMIT = 40; // cycles before a wait gives up

	// write enable masks, ar in the top bit down to r2
	localparam reg_we_t WE_AR = 9'b100000000;
	localparam reg_we_t WE_PC = 9'b010000000;
	localparam reg_we_t WE_DR = 9'b001000000;
	localparam reg_we_t WE_IR = 9'b000100000;
	localparam reg_we_t WE_R  = 9'b000010000;
	localparam reg_we_t WE_TR = 9'b000001000;
	localparam reg_we_t WE_AC = 9'b000000100;
	localparam reg_we_t WE_R1 = 9'b000000010;
	localparam reg_we_t WE_R2 = 9'b000000001;

	logic       clk;
	logic       rst_n;
	opcode_e    ir;
	logic       z;
	ctrl_word_t ctrl;
	logic       end_op;
	opcode_e    queued_op;    // next opcode for the ir model
	logic       z_next;
	ctrl_word_t exp_words[$]; // execute words of the running instruction
	int         n_checks;
	int         n_errors;
	bit         timed_out;

	tb_clock_gen #(.PERIOD(8)) u_clk_gen (.clk(clk));

	control_unit u_dut
	(
		.clk    (clk),
		.rst_n  (rst_n),
		.ir     (ir),
		.z      (z),
		.ctrl   (ctrl),
		.end_op (end_op)
	);

	// ir loads after a cycle with write_en.ir, as in the datapath
	always @(posedge clk)
	begin
		z <= z_next;
		if (ctrl.write_en.ir)
			ir <= queued_op;
	end

	// ------------------------------------------------------------
	// expected words
	// ------------------------------------------------------------
	function automatic ctrl_word_t make_word(input reg_we_t we, input inc_e inc,
			input alu_mode_e alu, input bus_src_e bus);
		return '{we, inc, alu, bus, reg_clr_t'(0)};
	endfunction

	// clear bits r, ac, tr, r1, r2 from the top
	function automatic ctrl_word_t clear_word(input reg_clr_t clr);
		return '{reg_we_t'(0), INC_NONE, ALU_ADD, BUS_IMEM, clr};
	endfunction

	function automatic ctrl_word_t fetch_word(input int step);
		case (step)
			0:       return make_word(WE_AR, INC_NONE, ALU_ADD, BUS_PC);
			1:       return make_word(WE_DR, INC_PC, ALU_ADD, BUS_IMEM);
			2:       return make_word(WE_DR, INC_NONE, ALU_ADD, BUS_IMEM); // memory wait
			default: return make_word(WE_AR | WE_IR, INC_NONE, ALU_ADD, BUS_DR);
		endcase
	endfunction

	function automatic bit is_defined_op(input logic [5:0] v);
		return v inside {6'd1, 6'd4, 6'd8, 6'd9, 6'd10, 6'd11, 6'd12, 6'd15, 6'd19,
			6'd23, 6'd24, 6'd25, 6'd26, 6'd27, 6'd28, 6'd38, 6'd39};
	endfunction

	function automatic void expected_exec(input logic [5:0] op, input logic zv);
		exp_words.delete();
		case (op)
			OP_MVACR:  exp_words.push_back(make_word(WE_R, INC_NONE, ALU_ADD, BUS_AC));
			OP_MVACR1: exp_words.push_back(make_word(WE_R1, INC_NONE, ALU_ADD, BUS_AC));
			OP_MVACR2: exp_words.push_back(make_word(WE_R2, INC_NONE, ALU_ADD, BUS_AC));
			OP_SUB:    exp_words.push_back(make_word(WE_AC, INC_NONE, ALU_SUB, BUS_R));
			OP_MULT:   exp_words.push_back(make_word(WE_AC, INC_NONE, ALU_MULT, BUS_R));
			OP_CLRR:   exp_words.push_back(clear_word(5'b10000));
			OP_CLRAC:  exp_words.push_back(clear_word(5'b01000));
			OP_CLRTR:  exp_words.push_back(clear_word(5'b00100));
			OP_CLRR1:  exp_words.push_back(clear_word(5'b00010));
			OP_CLRR2:  exp_words.push_back(clear_word(5'b00001));
			OP_INCAC:  exp_words.push_back(make_word('0, INC_AC, ALU_ADD, BUS_IMEM));
			OP_ADDTR, OP_ADDR1, OP_ADDR2:
			begin
				// add from the source register, then write the sum back to it
				case (op)
					OP_ADDTR: exp_words.push_back(make_word(WE_AC, INC_NONE, ALU_ADD, BUS_TR));
					OP_ADDR1: exp_words.push_back(make_word(WE_AC, INC_NONE, ALU_ADD, BUS_R1));
					default:  exp_words.push_back(make_word(WE_AC, INC_NONE, ALU_ADD, BUS_R2));
				endcase
				case (op)
					OP_ADDTR: exp_words.push_back(make_word(WE_TR, INC_NONE, ALU_ADD, BUS_AC));
					OP_ADDR1: exp_words.push_back(make_word(WE_R1, INC_NONE, ALU_ADD, BUS_AC));
					default:  exp_words.push_back(make_word(WE_R2, INC_NONE, ALU_ADD, BUS_AC));
				endcase
			end
			OP_LDAC:
			begin
				exp_words.push_back(make_word(WE_DR, INC_NONE, ALU_ADD, BUS_DMEM));
				exp_words.push_back(make_word(WE_DR, INC_NONE, ALU_ADD, BUS_DMEM));
				exp_words.push_back(make_word(WE_AC, INC_NONE, ALU_PASS, BUS_DR));
			end
			OP_JPNZ:
			begin
				if (zv)
					exp_words.push_back(make_word('0, INC_PC, ALU_ADD, BUS_IMEM)); // skipped
				else
				begin
					exp_words.push_back(make_word(WE_DR, INC_NONE, ALU_ADD, BUS_IMEM));
					exp_words.push_back(make_word(WE_DR, INC_NONE, ALU_ADD, BUS_IMEM));
					exp_words.push_back(make_word(WE_PC, INC_NONE, ALU_ADD, BUS_DR));
				end
			end
			default:   exp_words.push_back('0); // noop
		endcase
	endfunction

	// ------------------------------------------------------------
	// checking helpers
	// ------------------------------------------------------------
	function automatic void note_result(input bit ok);
		n_checks++;
		if (!ok)
			n_errors++;
	endfunction

	task automatic check_cycle(input ctrl_word_t w, input logic e, input string what);
		bit ok;
		@(negedge clk);
		ok = (ctrl === w && end_op === e);
		note_result(ok);
		assert (ok) else $display("FAIL %0t: %s gave ctrl %h end_op %b, expected %h %b",
			$time, what, ctrl, end_op, w, e);
	endtask

	// FETCH1 word, or the end_op pulse when end_pulse is set
	task automatic wait_for_word(input bit end_pulse, output int waited);
		bit seen;
		waited = 0;
		seen   = 1'b0;
		while (!seen && waited < WAIT_LIMIT)
		begin
			@(negedge clk);
			seen = end_pulse ? (end_op === 1'b1) : (ctrl === fetch_word(0));
			if (!seen)
				waited++;
		end
		if (!seen)
		begin
			$display("timeout: no %s within %0d cycles",
				end_pulse ? "end_op pulse" : "FETCH1 word", WAIT_LIMIT);
			timed_out = 1'b1;
		end
	endtask

	task automatic fetch_checks(input opcode_e op, input logic zv);
		int waited;
		bit ok;
		queued_op = op;
		z_next    = zv;
		wait_for_word(1'b0, waited);
		if (timed_out)
			return;
		ok = (waited == 0 && end_op === 1'b0); // fetch must follow the previous stage directly
		note_result(ok);
		assert (ok) else $display("FAIL %0t: fetch of op %0d began %0d cycles late, end_op %b",
			$time, op, waited, end_op);
		check_cycle(fetch_word(1), 1'b0, "FETCH2");
		check_cycle(fetch_word(2), 1'b0, "FETCH_WAIT");
		check_cycle(fetch_word(3), 1'b0, "FETCH3");
		check_cycle('0, 1'b0, "DECODE");
	endtask

	task automatic run_instr(input opcode_e op, input logic zv);
		fetch_checks(op, zv);
		expected_exec(op, zv);
		if (timed_out)
			return;
		foreach (exp_words[i])
			check_cycle(exp_words[i], 1'b0, $sformatf("op %0d execute word %0d", op, i));
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (timed_out)
			$display("test %s: stopped by a timeout", name);
		else
			$display("test %s: %0d errors", name, n_errors - errs_before);
	endtask

	// ------------------------------------------------------------
	// tests
	// ------------------------------------------------------------
	task automatic test_reset_fetch();
		int errs;
		errs = n_errors;
		for (int i = 0; i < 8; i++)
			check_cycle('0, 1'b0, "reset");
		@(posedge clk);
		rst_n <= 1'b1;
		check_cycle('0, 1'b0, "BOOT");
		run_instr(OP_CLRAC, 1'b0);
		report_test("reset and fetch", errs);
	endtask

	task automatic test_single_ops();
		opcode_e ops[11];
		int      errs;
		errs = n_errors;
		ops  = '{OP_MVACR, OP_MVACR1, OP_MVACR2, OP_SUB, OP_MULT, OP_CLRR,
			OP_CLRAC, OP_CLRTR, OP_CLRR1, OP_CLRR2, OP_INCAC};
		foreach (ops[i])
			run_instr(ops[i], 1'b0);
		report_test("single stage ops", errs);
	endtask

	task automatic test_add_ldac();
		int errs;
		errs = n_errors;
		run_instr(OP_ADDTR, 1'b0);
		run_instr(OP_ADDR1, 1'b0);
		run_instr(OP_ADDR2, 1'b0);
		run_instr(OP_LDAC, 1'b0);
		report_test("add family and ldac", errs);
	endtask

	task automatic test_jpnz();
		int errs;
		errs = n_errors;
		run_instr(OP_JPNZ, 1'b0);
		run_instr(OP_JPNZ, 1'b1);
		for (int i = 0; i < 4; i++)
			run_instr(OP_JPNZ, 1'($urandom));
		report_test("jpnz", errs);
	endtask

	task automatic test_noop_endop();
		int         errs;
		int         waited;
		bit         ok;
		logic [5:0] v;
		errs = n_errors;
		for (int i = 0; i < 3; i++)
		begin
			v = 6'($urandom);
			while (is_defined_op(v))
				v = 6'($urandom);
			run_instr(opcode_e'(v), 1'b0);
		end
		fetch_checks(OP_ENDOP, 1'b0);
		if (!timed_out)
			wait_for_word(1'b1, waited);
		if (!timed_out)
		begin
			ok = (waited == 0 && ctrl === '0);
			note_result(ok);
			assert (ok) else $display("FAIL %0t: end_op came %0d cycles late with ctrl %h",
				$time, waited, ctrl);
			for (int i = 0; i < 20; i++)
				check_cycle('0, 1'b0, "IDLE after ENDOP"); // pulse gone, no new fetch
		end
		report_test("noop and endop", errs);
	endtask

	initial
	begin
		rst_n     = 1'b0;
		ir        = opcode_e'(6'd0);
		z         = 1'b0;
		z_next    = 1'b0;
		queued_op = opcode_e'(6'd0);
		n_checks  = 0;
		n_errors  = 0;
		timed_out = 1'b0;
		void'($urandom(32'h7580));
		test_reset_fetch();
		test_single_ops();
		test_add_ldac();
		test_jpnz();
		test_noop_endop(); // halts the DUT, so it runs last
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0 && !timed_out)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== control_unit.f ====
source/cu_isa_pkg.sv
source/cu_ctrl_pkg.sv
source/cu_sequencer.sv
source/cu_microcode.sv
source/control_unit.sv
test/tb_clock_gen.sv
test/tb_control_unit.sv

// ==== Bender.yml ====
package:
  name: control_unit

sources:
  - files:
      - source/cu_isa_pkg.sv
      - source/cu_ctrl_pkg.sv
      - source/cu_sequencer.sv
      - source/cu_microcode.sv
      - source/control_unit.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_control_unit.sv
